//--- common/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath and address width
`define EXEC_XLEN 32

// register file index width
`define EXEC_REG_AW 5

// one strobe bit per byte lane
`define EXEC_STRB_W 4

// link value is the next sequential pc
`define EXEC_PC_STEP 4

`endif

//--- common/exec_pkg.sv
`include "exec_settings.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]   word_t;
    typedef logic [`EXEC_REG_AW-1:0] reg_addr_t;
    typedef logic [`EXEC_STRB_W-1:0] strb_t;
    typedef logic [2:0]              funct3_t;
    typedef logic [6:0]              funct7_t;

    // major opcodes of rv32i handled here, zero is a bubble
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011
    } opcode_e;

    // immediate word as delivered by the decoder, read per instruction format
    typedef union packed {
        word_t raw;
        struct packed {
            logic [`EXEC_XLEN-13:0] hi;
            logic signed [11:0]     imm12;   // signed 12-bit field
        } i_form;
        struct packed {
            logic [`EXEC_XLEN-14:0] hi;
            logic [11:0]            off;     // halfword offset, bits 12..1
            logic                   lsb;
        } b_form;
        struct packed {
            logic [19:0]            imm20;   // upper 20 bits
            logic [`EXEC_XLEN-21:0] lo;
        } u_form;
    } imm_u;

endpackage

//--- verilog/exec_latch.sv
`timescale 1ns/10ps

module exec_latch (
    input  logic                CLK,
    input  logic                rst,
    input  logic                flush,
    input  logic                stall,
    input  logic                mem_wait,

    input  exec_pkg::word_t     pc,
    input  exec_pkg::opcode_e   opcode,
    input  exec_pkg::reg_addr_t rd_addr,
    input  exec_pkg::word_t     rs1_data,
    input  exec_pkg::word_t     rs2_data,
    input  exec_pkg::funct3_t   funct3,
    input  exec_pkg::funct7_t   funct7,
    input  exec_pkg::imm_u      imm,

    output exec_pkg::word_t     q_pc,
    output exec_pkg::opcode_e   q_opcode,
    output exec_pkg::reg_addr_t q_rd_addr,
    output exec_pkg::word_t     q_rs1_data,
    output exec_pkg::word_t     q_rs2_data,
    output exec_pkg::funct3_t   q_funct3,
    output exec_pkg::funct7_t   q_funct7,
    output exec_pkg::imm_u      q_imm
);

    always_ff @(posedge CLK) begin
        if (rst || flush || stall) begin   // bubble, zero opcode decodes to nothing
            q_pc       <= '0;
            q_opcode   <= exec_pkg::opcode_e'('0);
            q_rd_addr  <= '0;
            q_rs1_data <= '0;
            q_rs2_data <= '0;
            q_funct3   <= '0;
            q_funct7   <= '0;
            q_imm      <= '0;
        end else if (!mem_wait) begin      // hold while memory busy
            q_pc       <= pc;
            q_opcode   <= opcode;
            q_rd_addr  <= rd_addr;
            q_rs1_data <= rs1_data;
            q_rs2_data <= rs2_data;
            q_funct3   <= funct3;
            q_funct7   <= funct7;
            q_imm      <= imm;
        end
    end

endmodule

//--- alu/alu_unit.sv
`timescale 1ns/10ps
`include "exec_settings.svh"

module alu_unit (
    input  exec_pkg::word_t     q_pc,
    input  exec_pkg::opcode_e   q_opcode,
    input  exec_pkg::reg_addr_t q_rd_addr,
    input  exec_pkg::word_t     q_rs1_data,
    input  exec_pkg::word_t     q_rs2_data,
    input  exec_pkg::funct3_t   q_funct3,
    input  exec_pkg::funct7_t   q_funct7,
    input  exec_pkg::imm_u      q_imm,

    output logic                reg_w_en,
    output exec_pkg::reg_addr_t reg_w_rd,
    output exec_pkg::word_t     reg_w_data
);

    localparam exec_pkg::funct7_t f7_base = 7'b0000000;
    localparam exec_pkg::funct7_t f7_alt  = 7'b0100000;   // sub, sra, srai

    exec_pkg::word_t imm_i;
    exec_pkg::word_t imm_upper;
    exec_pkg::word_t opnd_b;
    exec_pkg::word_t int_result;
    exec_pkg::word_t result;
    logic            is_reg;
    logic            f7_is_base;
    logic            f7_is_alt;
    logic            hit;

    assign imm_i = {{(`EXEC_XLEN-12){q_imm.i_form.imm12[11]}}, q_imm.i_form.imm12};
    assign imm_upper = exec_pkg::word_t'(q_imm.u_form.imm20) << 12;

    assign is_reg     = (q_opcode == exec_pkg::op_reg);
    assign f7_is_base = (q_funct7 == f7_base);
    assign f7_is_alt  = (q_funct7 == f7_alt);
    assign opnd_b     = is_reg ? q_rs2_data : imm_i;

    // shared integer datapath, shift amount from rs2 or the immediate
    always_comb begin
        case (q_funct3)
            3'b000:  int_result = (is_reg && f7_is_alt) ? q_rs1_data - opnd_b
                                                        : q_rs1_data + opnd_b;
            3'b001:  int_result = q_rs1_data << opnd_b[4:0];
            3'b010:  int_result = exec_pkg::word_t'($signed(q_rs1_data) < $signed(opnd_b));
            3'b011:  int_result = exec_pkg::word_t'(q_rs1_data < opnd_b);
            3'b100:  int_result = q_rs1_data ^ opnd_b;
            3'b101:  int_result = f7_is_alt ? exec_pkg::word_t'($signed(q_rs1_data) >>> opnd_b[4:0])
                                            : q_rs1_data >> opnd_b[4:0];
            3'b110:  int_result = q_rs1_data | opnd_b;
            default: int_result = q_rs1_data & opnd_b;
        endcase
    end

    always_comb begin
        hit    = 1'b1;
        result = int_result;
        case (q_opcode)
            exec_pkg::op_reg: begin
                hit = f7_is_base ||
                      (f7_is_alt && (q_funct3 == 3'b000 || q_funct3 == 3'b101));
            end
            exec_pkg::op_imm: begin
                // funct7 only qualifies the shift forms
                if (q_funct3 == 3'b001) begin
                    hit = f7_is_base;
                end else if (q_funct3 == 3'b101) begin
                    hit = f7_is_base || f7_is_alt;
                end
            end
            exec_pkg::op_lui:   result = imm_upper;
            exec_pkg::op_auipc: result = q_pc + imm_upper;
            exec_pkg::op_jal,
            exec_pkg::op_jalr:  result = q_pc + exec_pkg::word_t'(`EXEC_PC_STEP);   // link
            default: begin
                hit    = 1'b0;
                result = '0;
            end
        endcase
    end

    assign reg_w_en   = hit;
    assign reg_w_rd   = hit ? q_rd_addr : '0;
    assign reg_w_data = hit ? result : '0;

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/10ps
`include "exec_settings.svh"

module branch_unit (
    input  exec_pkg::word_t   q_pc,
    input  exec_pkg::opcode_e q_opcode,
    input  exec_pkg::word_t   q_rs1_data,
    input  exec_pkg::word_t   q_rs2_data,
    input  exec_pkg::funct3_t q_funct3,
    input  exec_pkg::imm_u    q_imm,

    output logic              jmp_do,
    output exec_pkg::word_t   jmp_pc
);

    exec_pkg::word_t off_b;
    exec_pkg::word_t imm_i;
    exec_pkg::word_t pc_target;
    exec_pkg::word_t reg_target;
    logic            is_eq;
    logic            is_lt;
    logic            is_ltu;

    assign off_b = {{(`EXEC_XLEN-13){q_imm.b_form.off[11]}}, q_imm.b_form.off, 1'b0};
    assign imm_i = {{(`EXEC_XLEN-12){q_imm.i_form.imm12[11]}}, q_imm.i_form.imm12};

    assign pc_target  = q_pc + off_b;
    assign reg_target = (q_rs1_data + imm_i) & ~exec_pkg::word_t'(1);   // bit 0 dropped

    assign is_eq  = (q_rs1_data == q_rs2_data);
    assign is_lt  = ($signed(q_rs1_data) < $signed(q_rs2_data));
    assign is_ltu = (q_rs1_data < q_rs2_data);

    always_comb begin
        jmp_do = 1'b0;
        jmp_pc = '0;
        case (q_opcode)
            exec_pkg::op_branch: begin
                if (q_funct3 != 3'b010 && q_funct3 != 3'b011) begin   // no 010/011 branch
                    jmp_pc = pc_target;
                    case (q_funct3)
                        3'b000:  jmp_do = is_eq;
                        3'b001:  jmp_do = !is_eq;
                        3'b100:  jmp_do = is_lt;
                        3'b101:  jmp_do = !is_lt;
                        3'b110:  jmp_do = is_ltu;
                        default: jmp_do = !is_ltu;
                    endcase
                end
            end
            exec_pkg::op_jal: begin
                jmp_do = 1'b1;
                jmp_pc = pc_target;
            end
            exec_pkg::op_jalr: begin
                jmp_do = 1'b1;
                jmp_pc = reg_target;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/lsu_request.sv
`timescale 1ns/10ps
`include "exec_settings.svh"

module lsu_request (
    input  exec_pkg::opcode_e   q_opcode,
    input  exec_pkg::reg_addr_t q_rd_addr,
    input  exec_pkg::word_t     q_rs1_data,
    input  exec_pkg::word_t     q_rs2_data,
    input  exec_pkg::funct3_t   q_funct3,
    input  exec_pkg::imm_u      q_imm,

    output logic                mem_r_en,
    output exec_pkg::reg_addr_t mem_r_rd,
    output exec_pkg::word_t     mem_r_addr,
    output exec_pkg::strb_t     mem_r_strb,
    output logic                mem_r_signed,

    output logic                mem_w_en,
    output exec_pkg::word_t     mem_w_addr,
    output exec_pkg::strb_t     mem_w_strb,
    output exec_pkg::word_t     mem_w_data
);

    exec_pkg::word_t ea;
    exec_pkg::strb_t size_strb;
    logic            is_load;
    logic            is_store;

    // effective address, shared by read and write side
    assign ea = q_rs1_data + {{(`EXEC_XLEN-12){q_imm.i_form.imm12[11]}}, q_imm.i_form.imm12};

    always_comb begin
        case (q_funct3[1:0])
            2'b00:   size_strb = 4'b0001;
            2'b01:   size_strb = 4'b0011;
            default: size_strb = 4'b1111;
        endcase
    end

    // lb lh lw lbu lhu / sb sh sw
    assign is_load  = (q_opcode == exec_pkg::op_load) &&
                      (q_funct3 != 3'b011 && q_funct3 != 3'b110 && q_funct3 != 3'b111);
    assign is_store = (q_opcode == exec_pkg::op_store) && (q_funct3[1:0] != 2'b11) &&
                      !q_funct3[2];

    // stores also raise a read with rd zero
    assign mem_r_en     = is_load || is_store;
    assign mem_r_rd     = is_load ? q_rd_addr : '0;
    assign mem_r_addr   = mem_r_en ? ea : '0;
    assign mem_r_strb   = mem_r_en ? size_strb : '0;
    assign mem_r_signed = is_load && !q_funct3[2] && !q_funct3[1];   // lb, lh

    assign mem_w_en   = is_store;
    assign mem_w_addr = is_store ? ea : '0;
    assign mem_w_strb = is_store ? size_strb : '0;
    assign mem_w_data = is_store ? q_rs2_data : '0;

endmodule

//--- verilog/exec_top.sv
`timescale 1ns/10ps

module exec_top (
    input  logic                CLK,
    input  logic                rst,
    input  logic                flush,
    input  logic                stall,
    input  logic                mem_wait,

    input  exec_pkg::word_t     pc,
    input  exec_pkg::opcode_e   opcode,
    input  exec_pkg::reg_addr_t rd_addr,
    input  exec_pkg::word_t     rs1_data,
    input  exec_pkg::word_t     rs2_data,
    input  exec_pkg::funct3_t   funct3,
    input  exec_pkg::funct7_t   funct7,
    input  exec_pkg::imm_u      imm,

    output logic                reg_w_en,
    output exec_pkg::reg_addr_t reg_w_rd,
    output exec_pkg::word_t     reg_w_data,

    output logic                mem_r_en,
    output exec_pkg::reg_addr_t mem_r_rd,
    output exec_pkg::word_t     mem_r_addr,
    output exec_pkg::strb_t     mem_r_strb,
    output logic                mem_r_signed,

    output logic                mem_w_en,
    output exec_pkg::word_t     mem_w_addr,
    output exec_pkg::strb_t     mem_w_strb,
    output exec_pkg::word_t     mem_w_data,

    output logic                jmp_do,
    output exec_pkg::word_t     jmp_pc
);

    exec_pkg::word_t     q_pc;
    exec_pkg::opcode_e   q_opcode;
    exec_pkg::reg_addr_t q_rd_addr;
    exec_pkg::word_t     q_rs1_data;
    exec_pkg::word_t     q_rs2_data;
    exec_pkg::funct3_t   q_funct3;
    exec_pkg::funct7_t   q_funct7;
    exec_pkg::imm_u      q_imm;

    exec_latch u_latch (
        .CLK        (CLK),
        .rst        (rst),
        .flush      (flush),
        .stall      (stall),
        .mem_wait   (mem_wait),
        .pc         (pc),
        .opcode     (opcode),
        .rd_addr    (rd_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .funct3     (funct3),
        .funct7     (funct7),
        .imm        (imm),
        .q_pc       (q_pc),
        .q_opcode   (q_opcode),
        .q_rd_addr  (q_rd_addr),
        .q_rs1_data (q_rs1_data),
        .q_rs2_data (q_rs2_data),
        .q_funct3   (q_funct3),
        .q_funct7   (q_funct7),
        .q_imm      (q_imm)
    );

    alu_unit u_alu (
        .q_pc       (q_pc),
        .q_opcode   (q_opcode),
        .q_rd_addr  (q_rd_addr),
        .q_rs1_data (q_rs1_data),
        .q_rs2_data (q_rs2_data),
        .q_funct3   (q_funct3),
        .q_funct7   (q_funct7),
        .q_imm      (q_imm),
        .reg_w_en   (reg_w_en),
        .reg_w_rd   (reg_w_rd),
        .reg_w_data (reg_w_data)
    );

    branch_unit u_branch (
        .q_pc       (q_pc),
        .q_opcode   (q_opcode),
        .q_rs1_data (q_rs1_data),
        .q_rs2_data (q_rs2_data),
        .q_funct3   (q_funct3),
        .q_imm      (q_imm),
        .jmp_do     (jmp_do),
        .jmp_pc     (jmp_pc)
    );

    lsu_request u_lsu (
        .q_opcode     (q_opcode),
        .q_rd_addr    (q_rd_addr),
        .q_rs1_data   (q_rs1_data),
        .q_rs2_data   (q_rs2_data),
        .q_funct3     (q_funct3),
        .q_imm        (q_imm),
        .mem_r_en     (mem_r_en),
        .mem_r_rd     (mem_r_rd),
        .mem_r_addr   (mem_r_addr),
        .mem_r_strb   (mem_r_strb),
        .mem_r_signed (mem_r_signed),
        .mem_w_en     (mem_w_en),
        .mem_w_addr   (mem_w_addr),
        .mem_w_strb   (mem_w_strb),
        .mem_w_data   (mem_w_data)
    );

endmodule

//--- test/exec_sva.sv
`timescale 1ns/10ps

module exec_sva (
    input logic                CLK,
    input logic                rst,
    input logic                reg_w_en,
    input exec_pkg::reg_addr_t reg_w_rd,
    input logic                mem_r_en,
    input logic                mem_w_en,
    input logic                jmp_do,
    input exec_pkg::word_t     jmp_pc
);

    a_rd_idle: assert property (@(posedge CLK) disable iff (rst) !reg_w_en |-> reg_w_rd == '0)
        else $error("reg_w_rd is nonzero while reg_w_en is low");

    // a store also raises the read side
    a_store_reads: assert property (@(posedge CLK) disable iff (rst) mem_w_en |-> mem_r_en)
        else $error("mem_w_en is high without mem_r_en");

    a_jump_even: assert property (@(posedge CLK) disable iff (rst) jmp_do |-> !jmp_pc[0])
        else $error("jump target is odd");

endmodule

bind exec_top exec_sva u_sva (
    .CLK      (CLK),
    .rst      (rst),
    .reg_w_en (reg_w_en),
    .reg_w_rd (reg_w_rd),
    .mem_r_en (mem_r_en),
    .mem_w_en (mem_w_en),
    .jmp_do   (jmp_do),
    .jmp_pc   (jmp_pc)
);

//--- test/exec_tb.sv
`timescale 1ns/10ps
`include "exec_settings.svh"

module exec_tb;

    localparam int         passes   = 3;
    localparam logic [1:0] c_normal = 2'd0;
    localparam logic [1:0] c_flush  = 2'd1;
    localparam logic [1:0] c_stall  = 2'd2;
    localparam logic [1:0] c_wait   = 2'd3;

    typedef struct packed {
        exec_pkg::opcode_e opcode;
        exec_pkg::funct3_t funct3;
        exec_pkg::funct7_t funct7;
        exec_pkg::word_t   imm;
        logic [1:0]        ctrl;
    } entry_t;

    // reference copy of the held instruction
    typedef struct packed {
        exec_pkg::word_t     pc;
        exec_pkg::opcode_e   op;
        exec_pkg::reg_addr_t rd;
        exec_pkg::word_t     rs1;
        exec_pkg::word_t     rs2;
        exec_pkg::funct3_t   f3;
        exec_pkg::funct7_t   f7;
        exec_pkg::imm_u      imm;
    } instr_t;

    logic                CLK = 1'b0;
    logic                rst, flush, stall, mem_wait;
    exec_pkg::word_t     pc, rs1_data, rs2_data;
    exec_pkg::opcode_e   opcode;
    exec_pkg::reg_addr_t rd_addr;
    exec_pkg::funct3_t   funct3;
    exec_pkg::funct7_t   funct7;
    exec_pkg::imm_u      imm;

    logic                reg_w_en, mem_r_en, mem_r_signed, mem_w_en, jmp_do;
    exec_pkg::reg_addr_t reg_w_rd, mem_r_rd;
    exec_pkg::word_t     reg_w_data, mem_r_addr, mem_w_addr, mem_w_data, jmp_pc;
    exec_pkg::strb_t     mem_r_strb, mem_w_strb;

    logic                e_reg_en, e_r_en, e_r_signed, e_w_en, e_jmp_do;
    exec_pkg::reg_addr_t e_reg_rd, e_r_rd;
    exec_pkg::word_t     e_reg_data, e_r_addr, e_w_addr, e_w_data, e_jmp_pc;
    exec_pkg::strb_t     e_r_strb, e_w_strb;

    instr_t      m;
    entry_t      tbl[$];
    logic [31:0] lcg_state;
    int          errors;
    int          cycles;
    int          cycle_limit;

    exec_top u_dut (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: stimulus table did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic exec_pkg::word_t int_op(input exec_pkg::funct3_t f3, input logic alt,
                                               input exec_pkg::word_t a,
                                               input exec_pkg::word_t b);
        exec_pkg::word_t fill;
        fill = a[`EXEC_XLEN-1] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0;   // sign bits for sra
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? ((a >> b[4:0]) | fill) : (a >> b[4:0]);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_entry(input exec_pkg::opcode_e op, input exec_pkg::funct3_t f3,
                             input exec_pkg::funct7_t f7, input exec_pkg::word_t im,
                             input logic [1:0] c);
        entry_t e;
        e = '{op, f3, f7, im, c};
        tbl.push_back(e);
    endtask

    task automatic fill_table();
        add_entry(exec_pkg::op_reg,    3'b000, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b000, 7'h20, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b001, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b010, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b011, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b100, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b101, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b101, 7'h20, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b110, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b111, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_lui,    3'b000, 7'h00, 32'h5555_5000, c_wait);
        add_entry(exec_pkg::op_imm,    3'b000, 7'h00, 32'hffff_f9c3, c_normal);
        add_entry(exec_pkg::op_imm,    3'b010, 7'h00, 32'h0000_0800, c_normal);
        add_entry(exec_pkg::op_imm,    3'b011, 7'h00, 32'h0000_0fff, c_normal);
        add_entry(exec_pkg::op_imm,    3'b001, 7'h00, 32'h0000_0007, c_normal);
        add_entry(exec_pkg::op_imm,    3'b101, 7'h00, 32'h0000_001f, c_normal);
        add_entry(exec_pkg::op_imm,    3'b101, 7'h20, 32'h0000_0404, c_normal);
        add_entry(exec_pkg::op_lui,    3'b000, 7'h00, 32'hfedc_b123, c_normal);
        add_entry(exec_pkg::op_auipc,  3'b000, 7'h00, 32'h8000_1000, c_normal);
        add_entry(exec_pkg::op_jal,    3'b000, 7'h00, 32'hffff_f802, c_normal);
        add_entry(exec_pkg::op_jalr,   3'b000, 7'h00, 32'h0000_0123, c_normal);
        add_entry(exec_pkg::op_reg,    3'b000, 7'h00, 32'h0000_0000, c_flush);
        add_entry(exec_pkg::op_jal,    3'b000, 7'h00, 32'h0000_0010, c_stall);
        add_entry(exec_pkg::op_branch, 3'b000, 7'h00, 32'h0000_0a40, c_normal);
        add_entry(exec_pkg::op_branch, 3'b001, 7'h00, 32'h0000_1ff4, c_normal);
        add_entry(exec_pkg::op_branch, 3'b100, 7'h00, 32'h0000_0a40, c_normal);
        add_entry(exec_pkg::op_branch, 3'b101, 7'h00, 32'h0000_1800, c_normal);
        add_entry(exec_pkg::op_branch, 3'b110, 7'h00, 32'h0000_0ffe, c_normal);
        add_entry(exec_pkg::op_branch, 3'b111, 7'h00, 32'h0000_0020, c_normal);
        add_entry(exec_pkg::op_load,   3'b000, 7'h00, 32'h0000_0010, c_normal);
        add_entry(exec_pkg::op_load,   3'b001, 7'h00, 32'h0000_0802, c_normal);
        add_entry(exec_pkg::op_load,   3'b101, 7'h00, 32'hffff_fffe, c_normal);
        add_entry(exec_pkg::op_load,   3'b010, 7'h00, 32'h0000_07fc, c_normal);
        add_entry(exec_pkg::op_store,  3'b010, 7'h00, 32'h0000_0100, c_wait);
        add_entry(exec_pkg::op_store,  3'b000, 7'h00, 32'h0000_0fff, c_normal);
        add_entry(exec_pkg::op_store,  3'b001, 7'h00, 32'h0000_0042, c_normal);
        add_entry(exec_pkg::op_store,  3'b010, 7'h00, 32'h0000_0804, c_normal);
        add_entry(exec_pkg::opcode_e'(7'h73), 3'b000, 7'h00, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_reg,    3'b000, 7'h01, 32'h0000_0000, c_normal);
        add_entry(exec_pkg::op_branch, 3'b010, 7'h00, 32'h0000_0a40, c_normal);
        add_entry(exec_pkg::op_load,   3'b011, 7'h00, 32'h0000_0010, c_normal);
        add_entry(exec_pkg::op_store,  3'b011, 7'h00, 32'h0000_0010, c_normal);
        add_entry(exec_pkg::op_imm,    3'b001, 7'h20, 32'h0000_0003, c_normal);
    endtask

    task automatic apply_entry(input entry_t e, input int idx);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        lcg_state = lcg_next(lcg_state);
        r1 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r2 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r3 = lcg_state;
        flush    = (e.ctrl == c_flush);
        stall    = (e.ctrl == c_stall);
        mem_wait = (e.ctrl == c_wait);
        pc       = {r3[31:2], 2'b00};
        opcode   = e.opcode;
        rd_addr  = exec_pkg::reg_addr_t'(idx + 1);
        rs1_data = r1;
        rs2_data = (r2[17:16] == 2'b00) ? r1 : r2;   // equal operands now and then
        funct3   = e.funct3;
        funct7   = e.funct7;
        imm.raw  = e.imm;
    endtask

    task automatic step_model(input logic [1:0] c);
        if (c == c_flush || c == c_stall) begin
            m = '0;
        end else if (c == c_normal) begin
            m = '{pc, opcode, rd_addr, rs1_data, rs2_data, funct3, funct7, imm};
        end
    endtask

    task automatic predict();
        exec_pkg::word_t si;
        exec_pkg::word_t sb;
        exec_pkg::word_t ea;
        exec_pkg::strb_t size;
        logic            alt;
        logic            ok;
        logic            ld;
        logic            st;
        si   = {{(`EXEC_XLEN-12){m.imm.i_form.imm12[11]}}, m.imm.i_form.imm12};
        sb   = {{(`EXEC_XLEN-13){m.imm.b_form.off[11]}}, m.imm.b_form.off, 1'b0};
        ea   = m.rs1 + si;
        size = {{2{m.f3[1]}}, m.f3[1] | m.f3[0], 1'b1};   // byte 0001, half 0011, word 1111
        alt  = (m.f7 == 7'h20);
        ok   = 1'b0;
        ld   = 1'b0;
        st   = 1'b0;
        {e_reg_en, e_reg_rd, e_reg_data, e_r_en, e_r_rd, e_r_addr, e_r_strb, e_r_signed,
         e_w_en, e_w_addr, e_w_strb, e_w_data, e_jmp_do, e_jmp_pc} = '0;
        case (m.op)
            exec_pkg::op_reg: begin
                ok = (m.f7 == 7'h00) || (alt && (m.f3 == 3'b000 || m.f3 == 3'b101));
                e_reg_data = int_op(m.f3, alt, m.rs1, m.rs2);
            end
            exec_pkg::op_imm: begin
                ok = (m.f3 == 3'b001) ? (m.f7 == 7'h00) :
                     (m.f3 == 3'b101) ? (m.f7 == 7'h00 || alt) : 1'b1;
                e_reg_data = int_op(m.f3, alt && m.f3 == 3'b101, m.rs1, si);
            end
            exec_pkg::op_lui: begin
                ok = 1'b1;
                e_reg_data = {m.imm.u_form.imm20, 12'h000};
            end
            exec_pkg::op_auipc: begin
                ok = 1'b1;
                e_reg_data = m.pc + {m.imm.u_form.imm20, 12'h000};
            end
            exec_pkg::op_jal: begin
                ok = 1'b1;
                e_reg_data = m.pc + `EXEC_PC_STEP;
                e_jmp_do = 1'b1;
                e_jmp_pc = m.pc + sb;
            end
            exec_pkg::op_jalr: begin
                ok = 1'b1;
                e_reg_data = m.pc + `EXEC_PC_STEP;
                e_jmp_do = 1'b1;
                e_jmp_pc = m.rs1 + si;
                e_jmp_pc[0] = 1'b0;
            end
            exec_pkg::op_branch: begin
                if (m.f3 != 3'b010 && m.f3 != 3'b011) begin
                    e_jmp_pc = m.pc + sb;
                    case (m.f3)
                        3'b000:  e_jmp_do = (m.rs1 == m.rs2);
                        3'b001:  e_jmp_do = (m.rs1 != m.rs2);
                        3'b100:  e_jmp_do = ($signed(m.rs1) < $signed(m.rs2));
                        3'b101:  e_jmp_do = ($signed(m.rs1) >= $signed(m.rs2));
                        3'b110:  e_jmp_do = (m.rs1 < m.rs2);
                        default: e_jmp_do = (m.rs1 >= m.rs2);
                    endcase
                end
            end
            exec_pkg::op_load:  ld = (m.f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
            exec_pkg::op_store: st = (m.f3 inside {3'b000, 3'b001, 3'b010});
            default: ;
        endcase
        if (ok) begin
            e_reg_en = 1'b1;
            e_reg_rd = m.rd;
        end else begin
            e_reg_data = '0;
        end
        if (ld || st) begin
            e_r_en   = 1'b1;
            e_r_addr = ea;
            e_r_strb = size;
        end
        if (ld) begin
            e_r_rd     = m.rd;
            e_r_signed = (m.f3 == 3'b000 || m.f3 == 3'b001);
        end
        if (st) begin
            e_w_en   = 1'b1;
            e_w_addr = ea;
            e_w_strb = size;
            e_w_data = m.rs2;
        end
    endtask

    task automatic check_word(input string name, input exec_pkg::word_t got,
                              input exec_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input exec_pkg::reg_addr_t got,
                             input exec_pkg::reg_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_strb(input string name, input exec_pkg::strb_t got,
                              input exec_pkg::strb_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_word("reg_w_en", exec_pkg::word_t'(reg_w_en), exec_pkg::word_t'(e_reg_en));
        check_reg("reg_w_rd", reg_w_rd, e_reg_rd);
        check_word("reg_w_data", reg_w_data, e_reg_data);
        check_word("mem_r_en", exec_pkg::word_t'(mem_r_en), exec_pkg::word_t'(e_r_en));
        check_reg("mem_r_rd", mem_r_rd, e_r_rd);
        check_word("mem_r_addr", mem_r_addr, e_r_addr);
        check_strb("mem_r_strb", mem_r_strb, e_r_strb);
        check_word("mem_r_signed", exec_pkg::word_t'(mem_r_signed),
                   exec_pkg::word_t'(e_r_signed));
        check_word("mem_w_en", exec_pkg::word_t'(mem_w_en), exec_pkg::word_t'(e_w_en));
        check_word("mem_w_addr", mem_w_addr, e_w_addr);
        check_strb("mem_w_strb", mem_w_strb, e_w_strb);
        check_word("mem_w_data", mem_w_data, e_w_data);
        check_word("jmp_do", exec_pkg::word_t'(jmp_do), exec_pkg::word_t'(e_jmp_do));
        check_word("jmp_pc", jmp_pc, e_jmp_pc);
    endtask

    initial begin
        rst      = 1'b1;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        pc       = '0;
        opcode   = exec_pkg::opcode_e'(7'h00);
        rd_addr  = '0;
        rs1_data = '0;
        rs2_data = '0;
        funct3   = '0;
        funct7   = '0;
        imm.raw  = '0;
        lcg_state = 32'he144;
        fill_table();
        cycle_limit = tbl.size() * passes * 2 + 50;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        m = '0;   // latch is cleared by reset
        predict();
        check_outputs();
        for (int p = 0; p < passes; p++) begin
            foreach (tbl[i]) begin
                apply_entry(tbl[i], i);
                step_model(tbl[i].ctrl);
                @(negedge CLK);
                predict();
                check_outputs();
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+common
common/exec_pkg.sv
verilog/exec_latch.sv
alu/alu_unit.sv
verilog/branch_unit.sv
verilog/lsu_request.sv
verilog/exec_top.sv
test/exec_sva.sv
test/exec_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exec_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/10ps

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
